//--- sources.f
rtl/mii_tx_pkg.sv
rtl/tx_byte_fifo.sv
rtl/tx_cfg_regs.sv
rtl/mii_nibble_tx.sv
rtl/mii_tx_top.sv
bench/mii_tx_assert.sv
bench/mii_tx_tb.sv

//--- Bender.yml
package:
  name: mii_tx

sources:
  - rtl/mii_tx_pkg.sv
  - rtl/tx_byte_fifo.sv
  - rtl/tx_cfg_regs.sv
  - rtl/mii_nibble_tx.sv
  - rtl/mii_tx_top.sv
  - target: simulation
    files:
      - bench/mii_tx_assert.sv
      - bench/mii_tx_tb.sv

//--- bench/mii_tx_tb.sv
/*
 * Testbench for the MII transmit path.
 * Random byte traffic, a byte scoreboard, register checks and the verdict.
 */
module mii_tx_tb;
	timeunit 1ns;
	timeprecision 100ps;

	logic phy_tx_clk;
	logic tx_rst2;
	logic wr_stb;
	logic [7:0] wr_data;
	logic full;
	mii_tx_pkg::cfg_wr_t cfg_wr;
	logic [1:0] cfg_raddr;
	logic [7:0] cfg_rdata;
	mii_tx_pkg::mii_tx_t mii;

	// reference model of the fifo contents in write order.
	logic [7:0] model_q[$];
	logic [7:0] exp_byte;
	logic exp_valid;
	logic [3:0] lo_nib;
	logic have_lo = 1'b0;
	logic clear_due = 1'b0;
	int unsigned err_count = 0;
	int unsigned cycles = 0;
	int unsigned cycle_limit = 20000;
	logic [31:0] lcg_state = 32'h44c3_c0f1;

	mii_tx_top dut0 (
		.phy_tx_clk(phy_tx_clk),
		.tx_rst2(tx_rst2),
		.wr_stb(wr_stb),
		.wr_data(wr_data),
		.full(full),
		.cfg_wr(cfg_wr),
		.cfg_raddr(cfg_raddr),
		.cfg_rdata(cfg_rdata),
		.mii(mii)
	);

	initial begin
		phy_tx_clk = 1'b0;
		forever #50 phy_tx_clk = ~phy_tx_clk;
	end

	//////////////////////////////
	// helpers
	//////////////////////////////

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_eq(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s = %02h, expected %02h", $time, name, got, exp);
			err_count++;
		end
	endtask

	// one random byte per cycle and the strobe dropped afterwards.
	task automatic write_frame(input int n);
		logic [31:0] r;
		for (int i = 0; i < n; i++) begin
			r = lcg_next();
			@(posedge phy_tx_clk);
			wr_stb <= 1'b1;
			wr_data <= r[23:16];
		end
		@(posedge phy_tx_clk);
		wr_stb <= 1'b0;
	endtask

	task automatic write_reg(input logic [1:0] addr, input logic [7:0] data);
		@(posedge phy_tx_clk);
		cfg_wr <= {1'b1, addr, data};
		@(posedge phy_tx_clk);
		cfg_wr.stb <= 1'b0;
	endtask

	// the read port is combinational so it is sampled mid cycle.
	task automatic check_reg(input logic [1:0] addr, input logic [7:0] exp, input string name);
		@(posedge phy_tx_clk);
		cfg_raddr <= addr;
		@(negedge phy_tx_clk);
		check_eq(name, cfg_rdata, exp);
	endtask

	task automatic check_en_low(input int n);
		repeat (n) begin
			@(negedge phy_tx_clk);
			check_eq("mii.en", 8'(mii.en), 8'h00);
		end
	endtask

	// wait for an empty model, a finished last byte and en back low.
	task automatic wait_drained();
		do begin
			@(negedge phy_tx_clk);
		end while (model_q.size() != 0 || have_lo || mii.en);
	endtask

	//////////////////////////////
	// scoreboard
	//////////////////////////////

	always @(posedge phy_tx_clk) begin
		if (!tx_rst2) begin
			// a byte leaves the model when its low nibble shows.
			if (mii.en && !have_lo) begin
				lo_nib = mii.data;
				have_lo = 1'b1;
				exp_valid = (model_q.size() != 0);
				if (exp_valid) begin
					exp_byte = model_q.pop_front();
				end else begin
					$display("Unexpected byte on mii at %0t ns, model queue is empty", $time);
					err_count++;
				end
			end else if (mii.en) begin
				have_lo = 1'b0;
				if (exp_valid && {mii.data, lo_nib} !== exp_byte) begin
					$display("Fail at %0t ns: mii.data = %02h, expected %02h", $time,
						{mii.data, lo_nib}, exp_byte);
					err_count++;
				end
			end
			// the flush lands one edge after the control write and drops writes on that edge.
			if (clear_due) begin
				model_q.delete();
				clear_due = 1'b0;
			end else if (wr_stb && !full) begin
				model_q.push_back(wr_data);
			end
			if (cfg_wr.stb && cfg_wr.addr == mii_tx_pkg::reg_ctrl &&
				cfg_wr.wdata.ctrl.clear) begin
				clear_due = 1'b1;
			end
		end
	end

	always @(posedge phy_tx_clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("Timeout, run still busy after %0d cycles", cycle_limit);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	//////////////////////////////
	// test sequence
	//////////////////////////////

	initial begin
		tx_rst2 = 1'b1;
		wr_stb = 1'b0;
		wr_data = '0;
		cfg_wr = '0;
		cfg_raddr = '0;
		repeat (5) @(posedge phy_tx_clk);
		tx_rst2 <= 1'b0;

		// reset defaults.
		check_en_low(2);
		check_reg(mii_tx_pkg::reg_ctrl, 8'h00, "cfg_rdata(ctrl)");
		check_reg(mii_tx_pkg::reg_ifg, 8'd24, "cfg_rdata(ifg)");
		check_reg(mii_tx_pkg::reg_status, 8'h00, "cfg_rdata(status)");

		// random frames with nibble order checked by the scoreboard.
		write_reg(mii_tx_pkg::reg_ctrl, 8'h01);
		repeat (6) begin
			write_frame(1 + (lcg_next() % 60));
			wait_drained();
		end

		// back to back frames with the default gap and then with 6.
		for (int g = 0; g < 2; g++) begin
			if (g == 1) begin
				write_reg(mii_tx_pkg::reg_ifg, 8'd6);
				check_reg(mii_tx_pkg::reg_ifg, 8'd6, "cfg_rdata(ifg)");
			end
			write_frame(20);
			// the refill starts once the first frame has left the model.
			do begin
				@(negedge phy_tx_clk);
			end while (model_q.size() != 0);
			write_frame(20);
			wait_drained();
		end

		// level counts up while held off.
		write_reg(mii_tx_pkg::reg_ctrl, 8'h00);
		write_frame(40);
		check_en_low(10);
		check_reg(mii_tx_pkg::reg_status, 8'd40, "cfg_rdata(status)");
		write_reg(mii_tx_pkg::reg_ctrl, 8'h01);
		wait_drained();

		// fill to the brim and drop two extra writes.
		write_reg(mii_tx_pkg::reg_ctrl, 8'h00);
		write_frame(128);
		@(negedge phy_tx_clk);
		check_eq("full", 8'(full), 8'h01);
		write_frame(2);
		check_reg(mii_tx_pkg::reg_status, 8'd128, "cfg_rdata(status)");
		write_reg(mii_tx_pkg::reg_ctrl, 8'h01);
		wait_drained();

		// clear while held off so nothing comes out after re-enable.
		write_reg(mii_tx_pkg::reg_ctrl, 8'h00);
		write_frame(10);
		write_reg(mii_tx_pkg::reg_ctrl, 8'h02);
		check_reg(mii_tx_pkg::reg_status, 8'h00, "cfg_rdata(status)");
		write_reg(mii_tx_pkg::reg_ctrl, 8'h01);
		check_en_low(20);
		// clear mid burst with can_tx also set in the same write.
		// the byte in flight completes and can_tx reads back low.
		write_frame(30);
		write_reg(mii_tx_pkg::reg_ctrl, 8'h03);
		wait_drained();
		check_reg(mii_tx_pkg::reg_ctrl, 8'h00, "cfg_rdata(ctrl)");
		write_reg(mii_tx_pkg::reg_ctrl, 8'h01);
		write_frame(12);
		wait_drained();

		repeat (5) @(posedge phy_tx_clk);
		$display("errors: scoreboard %0d, assertions %0d", err_count, dut0.u_assert.fail_count);
		if (err_count == 0 && dut0.u_assert.fail_count == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- bench/mii_tx_assert.sv
/*
 * MII framing checks, bound to the transmit top level.
 */
module mii_tx_assert (
	input logic phy_tx_clk,
	input logic tx_rst2,
	input mii_tx_pkg::mii_tx_t mii,
	input mii_tx_pkg::tx_cfg_t cfg
);
	timeunit 1ns;
	timeprecision 100ps;

	// failed assertions so far, read by the testbench.
	int unsigned fail_count = 0;
	logic [7:0] hi_run;
	logic [7:0] lo_run;
	// gap length the engine loaded at the end of the last burst.
	logic [4:0] gap_ref;
	logic seen_burst;

	always_ff @(posedge phy_tx_clk) begin
		if (tx_rst2) begin
			hi_run <= '0;
			lo_run <= '0;
			gap_ref <= mii_tx_pkg::ifg_default;
			seen_burst <= 1'b0;
		end else if (mii.en) begin
			hi_run <= hi_run + 1'b1;
			lo_run <= '0;
			gap_ref <= cfg.ifg_len;
			seen_burst <= 1'b1;
		end else begin
			hi_run <= '0;
			// saturate, gaps never need more than 31.
			if (lo_run != 8'hff) begin
				lo_run <= lo_run + 1'b1;
			end
		end
	end

	a_rst_quiet: assert property (@(posedge phy_tx_clk) $past(tx_rst2) |-> !mii.en)
		else begin
			$error("mii.en high while held in reset");
			fail_count++;
		end

	a_even_burst: assert property (@(posedge phy_tx_clk) disable iff (tx_rst2)
		$fell(mii.en) |-> !hi_run[0])
		else begin
			$error("burst of odd length on mii.en");
			fail_count++;
		end

	a_gap_len: assert property (@(posedge phy_tx_clk) disable iff (tx_rst2)
		($rose(mii.en) && seen_burst) |-> (lo_run >= 8'(gap_ref)))
		else begin
			$error("interframe gap shorter than ifg_len");
			fail_count++;
		end

	a_enable: assert property (@(posedge phy_tx_clk) disable iff (tx_rst2)
		$rose(mii.en) |-> $past(cfg.can_tx))
		else begin
			$error("mii.en rose with can_tx low");
			fail_count++;
		end

endmodule

bind mii_tx_top mii_tx_assert u_assert (
	.phy_tx_clk(phy_tx_clk),
	.tx_rst2(tx_rst2),
	.mii(mii),
	.cfg(cfg)
);

//--- rtl/mii_tx_top.sv
/*
 * MII transmit path top level.
 * Connects the byte fifo, the register block and the nibble engine.
 */
module mii_tx_top (
	input logic phy_tx_clk,
	input logic tx_rst2,
	input logic wr_stb,
	input logic [7:0] wr_data,
	output logic full,
	input mii_tx_pkg::cfg_wr_t cfg_wr,
	input logic [1:0] cfg_raddr,
	output logic [7:0] cfg_rdata,
	output mii_tx_pkg::mii_tx_t mii
);

	// settings from the registers to the engine.
	mii_tx_pkg::tx_cfg_t cfg;

	logic fifo_clear;
	logic [mii_tx_pkg::fifo_addr_w:0] fifo_level;
	logic [7:0] fifo_head;
	logic fifo_empty;
	logic fifo_pop;

	tx_byte_fifo u_fifo (
		.phy_tx_clk(phy_tx_clk),
		.tx_rst2(tx_rst2),
		.wr_stb(wr_stb),
		.wr_data(wr_data),
		.full(full),
		.clear(fifo_clear),
		.pop(fifo_pop),
		.head(fifo_head),
		.empty(fifo_empty),
		.level(fifo_level)
	);

	tx_cfg_regs u_regs (
		.phy_tx_clk(phy_tx_clk),
		.tx_rst2(tx_rst2),
		.cfg_wr(cfg_wr),
		.cfg_raddr(cfg_raddr),
		.cfg_rdata(cfg_rdata),
		.level(fifo_level),
		.cfg(cfg),
		.clear(fifo_clear)
	);

	// engine pulls from the fifo head.
	mii_nibble_tx u_engine (
		.phy_tx_clk(phy_tx_clk),
		.tx_rst2(tx_rst2),
		.cfg(cfg),
		.head(fifo_head),
		.empty(fifo_empty),
		.pop(fifo_pop),
		.mii(mii)
	);

endmodule

//--- rtl/mii_nibble_tx.sv
/*
 * MII transmit engine.
 * Sends each fifo byte as two nibbles, low first, and spaces bursts by the gap.
 */
module mii_nibble_tx (
	input logic phy_tx_clk,
	input logic tx_rst2,
	input mii_tx_pkg::tx_cfg_t cfg,
	input logic [7:0] head,
	input logic empty,
	output logic pop,
	output mii_tx_pkg::mii_tx_t mii
);

	// high while the second nibble of a byte is on the wire.
	logic hi_phase;
	// upper half of the byte in flight.
	logic [3:0] hi_nib;
	// set while the previous byte slot was transmitted.
	logic tx_prev;
	// interframe gap down counter.
	logic [4:0] gap_cnt;

	logic en_q;
	logic [3:0] data_q;
	logic start;

	////////////////////////////////
	// byte boundary decision
	////////////////////////////////

	// only evaluated when no byte is half sent.
	assign start = cfg.can_tx & ~empty & (gap_cnt == '0);

	// take the head byte as its low nibble goes out.
	assign pop = ~hi_phase & start;

	////////////////////////////////
	// control state
	////////////////////////////////

	always_ff @(posedge phy_tx_clk) begin
		if (tx_rst2) begin
			hi_phase <= 1'b0;
			tx_prev <= 1'b0;
			en_q <= 1'b0;
			gap_cnt <= '0;
		end else begin
			if (~hi_phase) begin
				// byte boundary.
				en_q <= start;
				hi_phase <= start;
				tx_prev <= start;
			end else begin
				// a started byte is always finished.
				en_q <= 1'b1;
				hi_phase <= 1'b0;
			end

			// burst just ended, arm the gap.
			if (~hi_phase && tx_prev && !start) begin
				gap_cnt <= cfg.ifg_len;
			end else if (gap_cnt != '0) begin
				gap_cnt <= gap_cnt - 1'b1;
			end
		end
	end

	////////////////////////////////
	// nibble datapath
	////////////////////////////////

	always_ff @(posedge phy_tx_clk) begin
		if (~hi_phase) begin
			if (start) begin
				data_q <= head[3:0];
				hi_nib <= head[7:4];
			end
		end else begin
			// stored upper half.
			data_q <= hi_nib;
		end
	end

	assign mii = '{en: en_q, data: data_q};

endmodule

//--- rtl/tx_cfg_regs.sv
/*
 * Transmit configuration registers.
 * Holds enable, gap length and the fifo clear strobe, reads back status.
 */
module tx_cfg_regs (
	input logic phy_tx_clk,
	input logic tx_rst2,
	input mii_tx_pkg::cfg_wr_t cfg_wr,
	input logic [1:0] cfg_raddr,
	output logic [7:0] cfg_rdata,
	input logic [mii_tx_pkg::fifo_addr_w:0] level,
	output mii_tx_pkg::tx_cfg_t cfg,
	output logic clear
);

	logic can_tx_q;
	logic [4:0] ifg_len_q;
	logic clear_q;

	// readback word, built through the same views as the writes.
	mii_tx_pkg::cfg_word_u rd_word;
	logic [7:0] level_sat;

	////////////////////////////////
	// write decode
	////////////////////////////////

	always_ff @(posedge phy_tx_clk) begin
		if (tx_rst2) begin
			can_tx_q <= 1'b0;
			ifg_len_q <= mii_tx_pkg::ifg_default;
			clear_q <= 1'b0;
		end else begin
			// clear is a single cycle strobe.
			clear_q <= 1'b0;
			if (cfg_wr.stb) begin
				case (cfg_wr.addr)
					mii_tx_pkg::reg_ctrl: begin
						// a clear also stops transmission.
						can_tx_q <= cfg_wr.wdata.ctrl.can_tx & ~cfg_wr.wdata.ctrl.clear;
						clear_q <= cfg_wr.wdata.ctrl.clear;
					end
					mii_tx_pkg::reg_ifg: begin
						ifg_len_q <= cfg_wr.wdata.ifg.ifg_len;
					end
					default: begin
					end
				endcase
			end
		end
	end

	assign cfg = '{can_tx: can_tx_q, ifg_len: ifg_len_q};
	assign clear = clear_q;

	////////////////////////////////
	// readback
	////////////////////////////////

	// fill level clipped to the 8-bit data port.
	assign level_sat = (level > 255) ? 8'hff : 8'(level);

	always_comb begin
		rd_word = '0;
		cfg_rdata = '0;
		case (cfg_raddr)
			mii_tx_pkg::reg_ctrl: begin
				rd_word.ctrl.can_tx = can_tx_q;
				cfg_rdata = rd_word;
			end
			mii_tx_pkg::reg_ifg: begin
				rd_word.ifg.ifg_len = ifg_len_q;
				cfg_rdata = rd_word;
			end
			mii_tx_pkg::reg_status: cfg_rdata = level_sat;
			default: cfg_rdata = '0;
		endcase
	end

endmodule

//--- rtl/tx_byte_fifo.sv
/*
 * Transmit byte FIFO, single clock, first word fall through.
 * Head byte is visible while not empty, flushed by a clear pulse.
 */
module tx_byte_fifo (
	input logic phy_tx_clk,
	input logic tx_rst2,
	input logic wr_stb,
	input logic [7:0] wr_data,
	output logic full,
	input logic clear,
	input logic pop,
	output logic [7:0] head,
	output logic empty,
	output logic [mii_tx_pkg::fifo_addr_w:0] level
);

	// storage, no reset needed.
	logic [7:0] mem [mii_tx_pkg::fifo_depth];

	logic [mii_tx_pkg::fifo_addr_w-1:0] wr_ptr;
	logic [mii_tx_pkg::fifo_addr_w-1:0] rd_ptr;
	logic [mii_tx_pkg::fifo_addr_w:0] count;

	logic push_ok;
	logic pop_ok;

	// writes while full are silently dropped.
	assign push_ok = wr_stb & ~full;
	// guard against a pop on an empty fifo.
	assign pop_ok = pop & ~empty;

	////////////////////////////////
	// storage
	////////////////////////////////

	always_ff @(posedge phy_tx_clk) begin
		if (push_ok) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	// head of queue, read combinationally.
	assign head = mem[rd_ptr];

	////////////////////////////////
	// pointers and occupancy
	////////////////////////////////

	always_ff @(posedge phy_tx_clk) begin
		if (tx_rst2 || clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push_ok) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// simultaneous push and pop leave the count unchanged.
			case ({push_ok, pop_ok})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// flags straight from the counter.
	assign full = (count == mii_tx_pkg::fifo_depth);
	assign empty = (count == '0);
	assign level = count;

endmodule

//--- rtl/mii_tx_pkg.sv
/*
 * MII transmit path shared definitions.
 * Sizes, register map and the structs passed between blocks.
 */
package mii_tx_pkg;

	////////////////////////////////
	// sizes and defaults
	////////////////////////////////

	// fifo address width, one extra bit is used for the fill level.
	localparam int fifo_addr_w = 7;
	localparam int fifo_depth = 1 << fifo_addr_w;

	// gap length after reset, in phy_tx_clk cycles.
	localparam logic [4:0] ifg_default = 5'd24;

	// register map.
	localparam logic [1:0] reg_ctrl = 2'd0;
	localparam logic [1:0] reg_ifg = 2'd1;
	localparam logic [1:0] reg_status = 2'd2;

	////////////////////////////////
	// register word views
	////////////////////////////////

	// control register layout, can_tx in bit 0.
	typedef struct packed {
		logic [5:0] rsvd;
		logic clear;
		logic can_tx;
	} ctrl_view_t;

	// gap register layout, length in the low five bits.
	typedef struct packed {
		logic [2:0] rsvd;
		logic [4:0] ifg_len;
	} ifg_view_t;

	// one write word, decoded by the target address.
	typedef union packed {
		ctrl_view_t ctrl;
		ifg_view_t ifg;
	} cfg_word_u;

	// host register write.
	typedef struct packed {
		logic stb;
		logic [1:0] addr;
		cfg_word_u wdata;
	} cfg_wr_t;

	// settings handed to the transmit engine.
	typedef struct packed {
		logic can_tx;
		logic [4:0] ifg_len;
	} tx_cfg_t;

	// phy side of the mii transmit interface.
	typedef struct packed {
		logic en;
		logic [3:0] data;
	} mii_tx_t;

endpackage
